/* rtl/scalar_settings.svh */
`ifndef SCALAR_SETTINGS_SVH
`define SCALAR_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Operand and result width
`define SCALAR_DATA_SIZE 32

// Low bits of operand B taken as power exponent
// Five bits bound the power loop to 31 iterations
`define SCALAR_EXP_SIZE 5

`endif

/* rtl/scalar_pkg.sv */
`default_nettype none

package scalar_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command opcodes
  ////////////////////////////////////////////////////////////////////////////

  // Codes 4 to 7 left unnamed and rejected by decode
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_MUL = 3'd2,
    OP_POW = 3'd3
  } opcode_t;

  ////////////////////////////////////////////////////////////////////////////
  // Execute FSM
  ////////////////////////////////////////////////////////////////////////////

  // Idle waits for issue, loop runs the power multiplies
  typedef enum logic [1:0] {
    EXEC_IDLE     = 2'd0,
    EXEC_POW_LOOP = 2'd1,
    EXEC_DONE     = 2'd2
  } exec_state_t;

endpackage

`default_nettype wire

/* rtl/scalar_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scalar_settings.svh"

interface scalar_op_if;

  import scalar_pkg::*;

  // One-cycle strobe for a legal command
  logic                         issue;
  // Registered command fields
  opcode_t                      opcode;
  logic [`SCALAR_DATA_SIZE-1:0] operand_a;
  logic [`SCALAR_DATA_SIZE-1:0] operand_b;

  // Decode side
  modport master (
    output issue,
    output opcode,
    output operand_a,
    output operand_b
  );

  // Execute side
  modport slave (
    input issue,
    input opcode,
    input operand_a,
    input operand_b
  );

endinterface

`default_nettype wire

/* rtl/scalar_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scalar_settings.svh"

module scalar_decode (
  input  wire                          CLK,
  input  wire                          RST,
  // Command from the source
  input  wire                          start,
  input  wire scalar_pkg::opcode_t     opcode,
  input  wire [`SCALAR_DATA_SIZE-1:0]  data_a,
  input  wire [`SCALAR_DATA_SIZE-1:0]  data_b,
  // Completion from result stage
  input  wire                          ready,
  output logic                         busy,
  output logic                         reject,
  scalar_op_if.master                  op
);

  import scalar_pkg::*;

  logic busy_q;
  logic accept;
  logic legal;

  ////////////////////////////////////////////////////////////////////////////
  // Command acceptance
  ////////////////////////////////////////////////////////////////////////////

  // Busy drops in the ready cycle itself
  assign busy   = busy_q & ~ready;
  // A start while busy is dropped entirely
  assign accept = start & ~busy;

  // Only legality check in the design
  assign legal = (opcode == OP_ADD) || (opcode == OP_SUB) ||
                 (opcode == OP_MUL) || (opcode == OP_POW);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q   <= 1'b0;
      op.issue <= 1'b0;
      reject   <= 1'b0;
    end else begin
      // Strobes last one cycle
      op.issue <= accept & legal;
      reject   <= accept & ~legal;
      // Clear on ready, a same-cycle accept wins
      if (ready) begin
        busy_q <= 1'b0;
      end
      if (accept) begin
        busy_q <= 1'b1;
      end
    end
  end

  // Command fields held until next accept
  always_ff @(posedge CLK) begin
    if (accept) begin
      op.opcode    <= opcode;
      op.operand_a <= data_a;
      op.operand_b <= data_b;
    end
  end

endmodule

`default_nettype wire

/* rtl/scalar_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scalar_settings.svh"

module scalar_execute (
  input  wire                           CLK,
  input  wire                           RST,
  scalar_op_if.slave                    op,
  // Result towards result stage
  output logic                          done,
  output logic [`SCALAR_DATA_SIZE-1:0]  value,
  output logic                          overflow
);

  import scalar_pkg::*;

  localparam int DW = `SCALAR_DATA_SIZE;
  localparam int EW = `SCALAR_EXP_SIZE;

  exec_state_t     state;
  logic [EW-1:0]   count;
  logic [EW-1:0]   exp_in;
  logic            start_op;
  logic [DW-1:0]   acc;
  logic [DW-1:0]   base_q;
  logic            ovf_q;
  logic [DW:0]     sum;
  logic [DW:0]     diff;
  logic [DW-1:0]   mul_lhs;
  logic [DW-1:0]   mul_rhs;
  logic [2*DW-1:0] product;

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////////////////////////////////////////

  assign exp_in   = op.operand_b[EW-1:0];
  assign start_op = (state == EXEC_IDLE) && op.issue;

  // Extra top bit catches carry and borrow
  assign sum  = {1'b0, op.operand_a} + {1'b0, op.operand_b};
  assign diff = {1'b0, op.operand_a} - {1'b0, op.operand_b};

  // Single multiplier, shared with the power loop
  always_comb begin
    if (state == EXEC_POW_LOOP) begin
      mul_lhs = acc;
      mul_rhs = base_q;
    end else begin
      mul_lhs = op.operand_a;
      mul_rhs = op.operand_b;
    end
  end

  assign product = mul_lhs * mul_rhs;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= EXEC_IDLE;
      count <= '0;
    end else begin
      case (state)
        EXEC_IDLE: begin
          if (op.issue) begin
            // Zero exponent needs no multiply
            if ((op.opcode == OP_POW) && (exp_in != '0)) begin
              state <= EXEC_POW_LOOP;
              count <= exp_in;
            end else begin
              state <= EXEC_DONE;
            end
          end
        end
        EXEC_POW_LOOP: begin
          count <= count - 1'b1;
          // Last multiply in this cycle
          if (count == EW'(1)) begin
            state <= EXEC_DONE;
          end
        end
        EXEC_DONE: begin
          state <= EXEC_IDLE;
        end
        default: begin
          state <= EXEC_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start_op) begin
      base_q <= op.operand_a;
      case (op.opcode)
        OP_ADD: begin
          acc   <= sum[DW-1:0];
          ovf_q <= sum[DW];
        end
        OP_SUB: begin
          // Borrow when A below B
          acc   <= diff[DW-1:0];
          ovf_q <= diff[DW];
        end
        OP_MUL: begin
          acc   <= product[DW-1:0];
          ovf_q <= |product[2*DW-1:DW];
        end
        OP_POW: begin
          // Accumulator starts at one
          acc   <= {{(DW-1){1'b0}}, 1'b1};
          ovf_q <= 1'b0;
        end
        default: begin
          acc   <= '0;
          ovf_q <= 1'b0;
        end
      endcase
    end else if (state == EXEC_POW_LOOP) begin
      // Low bits stay exact, overflow is sticky
      acc   <= product[DW-1:0];
      ovf_q <= ovf_q | (|product[2*DW-1:DW]);
    end
  end

  assign done     = (state == EXEC_DONE);
  assign value    = acc;
  assign overflow = ovf_q;

endmodule

`default_nettype wire

/* rtl/scalar_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scalar_settings.svh"

module scalar_result (
  input  wire                           CLK,
  input  wire                           RST,
  // From execute
  input  wire                           done,
  input  wire [`SCALAR_DATA_SIZE-1:0]   value,
  input  wire                           overflow,
  // From decode
  input  wire                           reject,
  // External result
  output logic                          ready,
  output logic [`SCALAR_DATA_SIZE-1:0]  data_out,
  output logic                          overflow_out,
  output logic                          error_out
);

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Values held between ready pulses
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready        <= 1'b0;
      data_out     <= '0;
      overflow_out <= 1'b0;
      error_out    <= 1'b0;
    end else begin
      // Default is no completion
      ready <= 1'b0;
      if (done) begin
        // Computed result
        ready        <= 1'b1;
        data_out     <= value;
        overflow_out <= overflow;
        error_out    <= 1'b0;
      end else if (reject) begin
        // Illegal opcode gives zero data and error
        ready        <= 1'b1;
        data_out     <= '0;
        overflow_out <= 1'b0;
        error_out    <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/scalar_arith_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scalar_settings.svh"

module scalar_arith_top (
  input  wire                           CLK,
  input  wire                           RST,
  // Command
  input  wire                           start,
  input  wire scalar_pkg::opcode_t      opcode,
  input  wire [`SCALAR_DATA_SIZE-1:0]   data_a,
  input  wire [`SCALAR_DATA_SIZE-1:0]   data_b,
  // Status and result
  output logic                          ready,
  output logic                          busy,
  output logic [`SCALAR_DATA_SIZE-1:0]  data_out,
  output logic                          overflow_out,
  output logic                          error_out
);

  // Decode to execute
  scalar_op_if op_if ();

  // Stage strobes and execute result
  logic                         reject;
  logic                         done;
  logic [`SCALAR_DATA_SIZE-1:0] value;
  logic                         overflow;

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  scalar_decode i_scalar_decode (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .opcode (opcode),
    .data_a (data_a),
    .data_b (data_b),
    .ready  (ready),
    .busy   (busy),
    .reject (reject),
    .op     (op_if.master)
  );

  scalar_execute i_scalar_execute (
    .CLK      (CLK),
    .RST      (RST),
    .op       (op_if.slave),
    .done     (done),
    .value    (value),
    .overflow (overflow)
  );

  // Ready also returns to decode
  scalar_result i_scalar_result (
    .CLK          (CLK),
    .RST          (RST),
    .done         (done),
    .value        (value),
    .overflow     (overflow),
    .reject       (reject),
    .ready        (ready),
    .data_out     (data_out),
    .overflow_out (overflow_out),
    .error_out    (error_out)
  );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 5
) (
  output logic CLK,
  output logic RST
);

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Reset released on a falling edge
  initial begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

`default_nettype wire

/* tests/tb_scalar_arith.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scalar_settings.svh"

module tb_scalar_arith;

  import scalar_pkg::*;

  localparam int DW          = `SCALAR_DATA_SIZE;
  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 5;
  // Power with exponent 31 is the longest command
  localparam int MAX_LAT     = (1 << `SCALAR_EXP_SIZE) + 2;
  localparam int N_CMDS      = 60;
  localparam int BUSY_WINDOW = 40;
  localparam int WATCHDOG_CYCLES =
    RST_CYCLES + 2 * (N_CMDS * (MAX_LAT + 1) + BUSY_WINDOW);

  logic          CLK;
  logic          RST;
  logic          start;
  opcode_t       opcode;
  logic [DW-1:0] data_a;
  logic [DW-1:0] data_b;
  logic          ready;
  logic          busy;
  logic [DW-1:0] data_out;
  logic          overflow_out;
  logic          error_out;

  int     errors = 0;
  int     checks = 0;
  integer seed   = 32'h44c7_5890;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) i_tb_clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  scalar_arith_top i_scalar_arith_top (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .opcode       (opcode),
    .data_a       (data_a),
    .data_b       (data_b),
    .ready        (ready),
    .busy         (busy),
    .data_out     (data_out),
    .overflow_out (overflow_out),
    .error_out    (error_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Exact 64-bit arithmetic
  // Latency counted from the start edge
  task automatic model_command(input logic [2:0] code, input logic [DW-1:0] a,
                               input logic [DW-1:0] b, output logic [DW-1:0] data,
                               output logic ovf, output logic err, output int lat);
    logic [2*DW-1:0] wide;
    logic [DW-1:0]   acc;
    int              e;
    err  = 1'b0;
    ovf  = 1'b0;
    data = '0;
    lat  = 3;
    case (code)
      3'd0: begin
        wide = {{DW{1'b0}}, a} + {{DW{1'b0}}, b};
        data = wide[DW-1:0];
        ovf  = |wide[2*DW-1:DW];
      end
      3'd1: begin
        wide = {{DW{1'b0}}, a} - {{DW{1'b0}}, b};
        data = wide[DW-1:0];
        ovf  = (a < b);
      end
      3'd2: begin
        wide = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
        data = wide[DW-1:0];
        ovf  = |wide[2*DW-1:DW];
      end
      3'd3: begin
        // Only the low exponent bits count
        e   = b[`SCALAR_EXP_SIZE-1:0];
        acc = 1;
        for (int i = 0; i < e; i++) begin
          wide = {{DW{1'b0}}, acc} * {{DW{1'b0}}, a};
          ovf  = ovf | (|wide[2*DW-1:DW]);
          acc  = wide[DW-1:0];
        end
        data = acc;
        lat  = e + 3;
      end
      default: begin
        err = 1'b1;
        lat = 2;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Command driver and checker
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_command(input logic [2:0] code, input logic [DW-1:0] a,
                             input logic [DW-1:0] b);
    logic [DW-1:0] exp_data;
    logic          exp_ovf;
    logic          exp_err;
    int            exp_lat;
    int            cycles;
    model_command(code, a, b, exp_data, exp_ovf, exp_err, exp_lat);
    @(negedge CLK);
    start  = 1'b1;
    opcode = opcode_t'(code);
    data_a = a;
    data_b = b;
    cycles = 0;
    // Busy must stay high until ready
    do begin
      @(negedge CLK);
      start  = 1'b0;
      cycles = cycles + 1;
      if (!ready && !busy) begin
        $display("[ERROR] %0t: busy low mid-command, op %0d cycle %0d", $time, code, cycles);
        errors++;
      end
    end while (!ready && cycles < MAX_LAT + 4);
    checks++;
    if (!ready) begin
      $display("No ready pulse for op %0d a=%h b=%h after %0d cycles", code, a, b, cycles);
      errors++;
    end else begin
      if (cycles != exp_lat) begin
        $display("[ERROR] %0t: op %0d latency %0d, expected %0d", $time, code, cycles,
                 exp_lat);
        errors++;
      end
      if (busy) begin
        $display("[ERROR] %0t: busy still high with ready, op %0d", $time, code);
        errors++;
      end
      if (data_out !== exp_data || overflow_out !== exp_ovf || error_out !== exp_err) begin
        $display("[ERROR] %0t: op %0d a=%h b=%h got %h/%b/%b, expected %h/%b/%b", $time,
                 code, a, b, data_out, overflow_out, error_out, exp_data, exp_ovf, exp_err);
        errors++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic exercise_add_sub();
    run_command(3'd0, 32'hffff_ffff, 32'h1);
    run_command(3'd0, 32'h1, 32'h2);
    run_command(3'd1, 32'h0, 32'h1);
    run_command(3'd1, 32'h5, 32'h3);
    repeat (8) begin
      run_command(3'd0, $random(seed), $random(seed));
      run_command(3'd1, $random(seed), $random(seed));
    end
  endtask

  task automatic check_multiply();
    run_command(3'd2, 32'h0, 32'h1234_5678);
    run_command(3'd2, 32'h1, 32'hdead_beef);
    run_command(3'd2, 32'hffff_ffff, 32'hffff_ffff);
    run_command(3'd2, 32'h1_0000, 32'h1_0000);
    run_command(3'd2, 32'hffff, 32'hffff);
    repeat (8) run_command(3'd2, $random(seed), $random(seed));
  endtask

  task automatic cover_power();
    logic [DW-1:0] bases [4] = '{32'd0, 32'd1, 32'd2, 32'd3};
    logic [DW-1:0] exps  [3] = '{32'd0, 32'd1, 32'd31};
    foreach (bases[i]) begin
      foreach (exps[j]) run_command(3'd3, bases[i], exps[j]);
    end
    // Upper bits of data_b ignored
    // Effective exponent 3
    run_command(3'd3, 32'd5, 32'hffff_ffe3);
    repeat (3) run_command(3'd3, $random(seed) & 32'hf, $random(seed));
    repeat (3) run_command(3'd3, $random(seed), $random(seed));
  endtask

  task automatic reject_illegal();
    for (int code = 4; code < 8; code++) begin
      run_command(3'(code), $random(seed), $random(seed));
    end
    // Error flag clears on a legal result
    run_command(3'd0, 32'd7, 32'd8);
  endtask

  // Second and third start during a long power are dropped
  task automatic busy_lockout();
    logic [DW-1:0] exp_data;
    logic [DW-1:0] got_data;
    logic          exp_ovf;
    logic          got_ovf;
    logic          exp_err;
    logic          got_err;
    int            exp_lat;
    int            readys;
    int            ready_at;
    model_command(3'd3, 32'd2, 32'd20, exp_data, exp_ovf, exp_err, exp_lat);
    readys   = 0;
    ready_at = 0;
    @(negedge CLK);
    start  = 1'b1;
    opcode = OP_POW;
    data_a = 32'd2;
    data_b = 32'd20;
    for (int cyc = 1; cyc <= BUSY_WINDOW; cyc++) begin
      @(negedge CLK);
      start = (cyc == 5) || (cyc == 9);
      if (cyc == 5) begin
        opcode = OP_ADD;
        data_a = 32'd7;
        data_b = 32'd9;
      end
      if (cyc == 9) begin
        // An accepted illegal code would give an early ready
        opcode = opcode_t'(3'd5);
      end
      if (ready) begin
        readys++;
        ready_at = cyc;
        got_data = data_out;
        got_ovf  = overflow_out;
        got_err  = error_out;
      end
    end
    checks++;
    if (readys != 1 || ready_at != exp_lat || got_data !== exp_data ||
        got_ovf !== exp_ovf || got_err !== exp_err) begin
      $display("[ERROR] %0t: %0d ready pulses, last at %0d with %h/%b/%b",
               $time, readys, ready_at, got_data, got_ovf, got_err);
      $display("[ERROR] %0t: expected one at %0d with %h/%b/%b",
               $time, exp_lat, exp_data, exp_ovf, exp_err);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    start  = 1'b0;
    opcode = OP_ADD;
    data_a = '0;
    data_b = '0;
    @(negedge RST);
    @(negedge CLK);
    checks++;
    if (busy || ready || error_out || overflow_out || data_out != '0) begin
      $display("[ERROR] %0t: outputs not idle after reset", $time);
      errors++;
    end
    exercise_add_sub();
    check_multiply();
    cover_power();
    reject_illegal();
    busy_lockout();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/scalar_pkg.sv
rtl/scalar_op_if.sv
rtl/scalar_decode.sv
rtl/scalar_execute.sv
rtl/scalar_result.sv
rtl/scalar_arith_top.sv
tests/tb_clock_gen.sv
tests/tb_scalar_arith.sv
